// ==== router_pkg.sv ====
// Shared port numbering and vector types that the router RTL and its testbench import.
package router_pkg;

        // ######################################################################### 
        // Port numbering
        // #########################################################################

        localparam int num_ports = 5;   // Local plus the four compass directions.

        // Port number as carried in the top three bits of every flit.
        typedef logic [2:0] port_id_t;

        // One-hot port vector. Bit i stands for port i.
        typedef logic [num_ports-1:0] port_sel_t;

        // Credit and occupancy count, good for up to 15 entries.
        typedef logic [3:0] credit_cnt_t;

        localparam port_id_t port_local = 3'd0;
        localparam port_id_t port_north = 3'd1;
        localparam port_id_t port_east  = 3'd2;
        localparam port_id_t port_south = 3'd3;
        localparam port_id_t port_west  = 3'd4;    // Highest legal port number.

        // #########################################################################
        // Destination codes 5 to 7 are not assigned to any port.
        // #########################################################################

endpackage

// ==== input_buffer.sv ====
// Input FIFO for one router port that router_top instantiates once per input direction.
`timescale 1ns/1ps

module input_buffer
        import router_pkg::*;
#(
        parameter int data_w    = 32,
        parameter int vch_w     = 2,
        parameter int buf_depth = 4
) (
        input  logic              clk,
        input  logic              reset,
        input  logic              in_valid,
        input  logic [data_w-1:0] in_data,
        input  logic [vch_w-1:0]  in_vch,
        input  logic              pop,
        output port_sel_t         request,
        output logic [data_w-1:0] head_data,
        output logic [vch_w-1:0]  head_vch,
        output logic              in_credit
);

        localparam int ptr_w = $clog2(buf_depth);
        localparam logic [ptr_w-1:0] last_ptr = ptr_w'(buf_depth - 1);

        logic [data_w-1:0] mem_data [buf_depth];
        logic [vch_w-1:0]  mem_vch  [buf_depth];
        logic [ptr_w-1:0]  wr_ptr;
        logic [ptr_w-1:0]  rd_ptr;
        credit_cnt_t       count;          // Flits held in the memory, not counting the head.
        logic              head_valid;
        logic              head_load;
        port_id_t          head_dest;

        // The head register refills when it is empty or being popped.
        assign head_load = (count != '0) && (!head_valid || pop);

        assign head_dest = head_data[data_w-1 -: $bits(port_id_t)];
        assign request   = head_valid ? (port_sel_t'(1) << head_dest) : '0;

        always_ff @(posedge clk) begin
                if (in_valid) begin
                        mem_data[wr_ptr] <= in_data;
                        mem_vch[wr_ptr]  <= in_vch;
                end
                if (head_load) begin
                        head_data <= mem_data[rd_ptr];
                        head_vch  <= mem_vch[rd_ptr];
                end
        end

        // #########################################################################
        // Pointers, occupancy and credit return
        // #########################################################################

        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_ptr     <= '0;
                        rd_ptr     <= '0;
                        count      <= '0;
                        head_valid <= 1'b0;
                        in_credit  <= 1'b0;
                end else begin
                        if (in_valid) begin
                                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
                        end
                        if (head_load) begin
                                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
                        end
                        count <= count + credit_cnt_t'(in_valid) - credit_cnt_t'(head_load);
                        if (head_load) begin
                                head_valid <= 1'b1;
                        end else if (pop) begin
                                head_valid <= 1'b0;
                        end
                        in_credit <= pop;       // One credit back per flit that leaves.
                end
        end

endmodule

// ==== switch_allocator.sv ====
// Round-robin switch allocator that grants each router output to one requesting input buffer.
`timescale 1ns/1ps

module switch_allocator
        import router_pkg::*;
(
        input  logic                      clk,
        input  logic                      reset,
        input  port_sel_t [num_ports-1:0] request,
        input  logic      [num_ports-1:0] can_send,
        output port_sel_t [num_ports-1:0] grant_o,
        output logic      [num_ports-1:0] pop
);

        port_id_t rr_ptr [num_ports];   // Highest priority input per output.
        port_id_t winner [num_ports];

        // #########################################################################
        // Arbitration
        // #########################################################################

        // Each output scans from its pointer up to the last input, then wraps
        // around to input 0. An input requests a single output, so it can win
        // at most once per cycle and the pop vector is a plain OR of grants.
        always_comb begin
                logic found;

                grant_o = '0;
                pop     = '0;
                for (int o = 0; o < num_ports; o++) begin
                        found     = 1'b0;
                        winner[o] = rr_ptr[o];
                        if (can_send[o]) begin
                                for (int i = 0; i < num_ports; i++) begin
                                        if (!found && request[i][o] &&
                                            port_id_t'(i) >= rr_ptr[o]) begin
                                                found         = 1'b1;
                                                winner[o]     = port_id_t'(i);
                                                grant_o[o][i] = 1'b1;
                                        end
                                end
                                for (int i = 0; i < num_ports; i++) begin
                                        if (!found && request[i][o]) begin
                                                found         = 1'b1;
                                                winner[o]     = port_id_t'(i);
                                                grant_o[o][i] = 1'b1;
                                        end
                                end
                        end
                        pop = pop | grant_o[o];
                end
        end

        // #########################################################################
        // Pointer update
        // #########################################################################

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int o = 0; o < num_ports; o++) begin
                                rr_ptr[o] <= port_local;
                        end
                end else begin
                        for (int o = 0; o < num_ports; o++) begin
                                // The winner drops to lowest priority on this output.
                                if (grant_o[o] != '0) begin
                                        rr_ptr[o] <= (winner[o] == port_west) ?
                                                     port_local : winner[o] + 1'b1;
                                end
                        end
                end
        end

endmodule

// ==== output_port.sv ====
// Output stage for one router direction with flit select, output register and credit counter.
`timescale 1ns/1ps

module output_port
        import router_pkg::*;
#(
        parameter int data_w      = 32,
        parameter int vch_w       = 2,
        parameter int out_credits = 4
) (
        input  logic                             clk,
        input  logic                             reset,
        input  port_sel_t                        grant,
        input  logic [num_ports-1:0][data_w-1:0] head_data,
        input  logic [num_ports-1:0][vch_w-1:0]  head_vch,
        input  logic                             out_credit,
        output logic                             can_send,
        output logic                             out_valid,
        output logic [data_w-1:0]                out_data,
        output logic [vch_w-1:0]                 out_vch
);

        logic [data_w-1:0] sel_data;
        logic [vch_w-1:0]  sel_vch;
        logic              sending;
        credit_cnt_t       credit_cnt;

        // #########################################################################
        // One-hot flit select
        // #########################################################################

        // Only an exact one-hot grant picks a lane. Anything else gives zero.
        always_comb begin
                sel_data = '0;
                sel_vch  = '0;
                for (int i = 0; i < num_ports; i++) begin
                        if (grant == (port_sel_t'(1) << i)) begin
                                sel_data = head_data[i];
                                sel_vch  = head_vch[i];
                        end
                end
        end

        assign sending  = |grant;
        assign can_send = (credit_cnt != '0);

        always_ff @(posedge clk) begin
                out_data <= sel_data;
                out_vch  <= sel_vch;
        end

        // #########################################################################
        // Output valid and downstream credits
        // #########################################################################

        always_ff @(posedge clk) begin
                if (reset) begin
                        out_valid  <= 1'b0;
                        credit_cnt <= credit_cnt_t'(out_credits);
                end else begin
                        out_valid  <= sending;
                        // A send and a returned credit in one cycle cancel out.
                        credit_cnt <= credit_cnt - credit_cnt_t'(sending)
                                      + credit_cnt_t'(out_credit);
                end
        end

endmodule

// ==== router_top.sv ====
// Five-port router top level that the testbench instantiates as the DUT.
`timescale 1ns/1ps

module router_top
        import router_pkg::*;
#(
        parameter int data_w      = 32,
        parameter int vch_w       = 2,
        parameter int buf_depth   = 4,
        parameter int out_credits = 4
) (
        input  logic                        clk,
        input  logic                        reset,
        input  logic [num_ports-1:0]        in_valid,
        input  logic [num_ports*data_w-1:0] in_data,
        input  logic [num_ports*vch_w-1:0]  in_vch,
        output logic [num_ports-1:0]        in_credit,
        output logic [num_ports-1:0]        out_valid,
        output logic [num_ports*data_w-1:0] out_data,
        output logic [num_ports*vch_w-1:0]  out_vch,
        input  logic [num_ports-1:0]        out_credit
);

        port_sel_t [num_ports-1:0]        request;
        port_sel_t [num_ports-1:0]        grant_o;
        logic      [num_ports-1:0]        pop;
        logic      [num_ports-1:0]        can_send;
        logic [num_ports-1:0][data_w-1:0] head_data;
        logic [num_ports-1:0][vch_w-1:0]  head_vch;

        // #########################################################################
        // Input buffers, one per direction
        // #########################################################################

        for (genvar p = 0; p < num_ports; p++) begin : g_in
                input_buffer #(
                        .data_w    (data_w),
                        .vch_w     (vch_w),
                        .buf_depth (buf_depth)
                ) u_in (
                        .clk       (clk),
                        .reset     (reset),
                        .in_valid  (in_valid[p]),
                        .in_data   (in_data[p*data_w +: data_w]),
                        .in_vch    (in_vch[p*vch_w +: vch_w]),
                        .pop       (pop[p]),
                        .request   (request[p]),
                        .head_data (head_data[p]),
                        .head_vch  (head_vch[p]),
                        .in_credit (in_credit[p])
                );
        end

        switch_allocator u_alloc (
                .clk      (clk),
                .reset    (reset),
                .request  (request),
                .can_send (can_send),
                .grant_o  (grant_o),
                .pop      (pop)
        );

        // Every output sees all five head flits and picks one by its grant.
        for (genvar p = 0; p < num_ports; p++) begin : g_out
                output_port #(
                        .data_w      (data_w),
                        .vch_w       (vch_w),
                        .out_credits (out_credits)
                ) u_out (
                        .clk        (clk),
                        .reset      (reset),
                        .grant      (grant_o[p]),
                        .head_data  (head_data),
                        .head_vch   (head_vch),
                        .out_credit (out_credit[p]),
                        .can_send   (can_send[p]),
                        .out_valid  (out_valid[p]),
                        .out_data   (out_data[p*data_w +: data_w]),
                        .out_vch    (out_vch[p*vch_w +: vch_w])
                );
        end

endmodule

// ==== router_chk.sv ====
// Bound assertions for the router allocator grants and the output credit protocol.
`timescale 1ns/1ps

module router_chk
        import router_pkg::*;
(
        input logic                      clk,
        input logic                      reset,
        input port_sel_t [num_ports-1:0] grant_o
);

        port_sel_t [num_ports-1:0] by_input;    // Transposed grants, one row per input.

        always_comb begin
                for (int o = 0; o < num_ports; o++) begin
                        for (int i = 0; i < num_ports; i++) begin
                                by_input[i][o] = grant_o[o][i];
                        end
                end
        end

        for (genvar o = 0; o < num_ports; o++) begin : g_prop
                a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
                        $onehot0(grant_o[o]))
                        else $error("grant for output %0d is not one-hot", o);
                a_single_output: assert property (@(posedge clk) disable iff (reset)
                        $onehot0(by_input[o]))
                        else $error("input %0d granted by more than one output", o);
        end

endmodule

module credit_chk
        import router_pkg::*;
(
        input logic        clk,
        input logic        reset,
        input logic        out_valid,
        input credit_cnt_t credit_cnt
);

        // A flit on the output was sent from the count of the edge before.
        a_valid_credit: assert property (@(posedge clk) disable iff (reset)
                out_valid |-> ($past(credit_cnt) != '0))
                else $error("out_valid raised with zero downstream credit");

endmodule

bind switch_allocator router_chk u_chk (
        .clk      (clk),
        .reset    (reset),
        .grant_o  (grant_o)
);

bind output_port credit_chk u_credit_chk (
        .clk        (clk),
        .reset      (reset),
        .out_valid  (out_valid),
        .credit_cnt (credit_cnt)
);

// ==== router_tb.sv ====
// Testbench for router_top that replays the pattern file and checks flits and credits.
`timescale 1ns/1ps

module router_tb
        import router_pkg::*;
;

        localparam int data_w      = 32;
        localparam int vch_w       = 2;
        localparam int buf_depth   = 4;
        localparam int out_credits = 4;
        localparam int max_flits   = 64;
        localparam int wait_limit  = 2000;

        logic                        clk = 1'b0;
        logic                        reset = 1'b1;
        logic [num_ports-1:0]        in_valid;
        logic [num_ports*data_w-1:0] in_data;
        logic [num_ports*vch_w-1:0]  in_vch;
        logic [num_ports-1:0]        in_credit;
        logic [num_ports-1:0]        out_valid;
        logic [num_ports*data_w-1:0] out_data;
        logic [num_ports*vch_w-1:0]  out_vch;
        logic [num_ports-1:0]        out_credit = '0;

        logic              drv_valid [num_ports];
        logic [data_w-1:0] drv_data  [num_ports];
        logic [vch_w-1:0]  drv_vch   [num_ports];

        int                f_src  [max_flits];
        int                f_dest [max_flits];
        logic [vch_w-1:0]  f_vch  [max_flits];
        logic [data_w-1:0] f_data [max_flits];
        int                n_flits = 0;

        logic [vch_w+data_w-1:0] exp_q [num_ports][num_ports][$];
        int  send_credit [num_ports];
        int  sent        [num_ports];
        int  credits_back[num_ports];
        int  received    [num_ports];
        int  returned    [num_ports];
        int  pend_credit [num_ports];
        int  hold_left   [num_ports];
        int  passed      [num_ports][num_ports];
        int  errors   = 0;
        int  timeouts = 0;
        bit  started  = 1'b0;

        router_top #(
                .data_w      (data_w),
                .vch_w       (vch_w),
                .buf_depth   (buf_depth),
                .out_credits (out_credits)
        ) dut (
                .clk        (clk),
                .reset      (reset),
                .in_valid   (in_valid),
                .in_data    (in_data),
                .in_vch     (in_vch),
                .in_credit  (in_credit),
                .out_valid  (out_valid),
                .out_data   (out_data),
                .out_vch    (out_vch),
                .out_credit (out_credit)
        );

        for (genvar p = 0; p < num_ports; p++) begin : g_pack
                assign in_valid[p]                  = drv_valid[p];
                assign in_data[p*data_w +: data_w] = drv_data[p];
                assign in_vch[p*vch_w +: vch_w]    = drv_vch[p];
        end

        always #20 clk = ~clk;

        // ##########################################################################
        // Stimulus
        // ##########################################################################

        task automatic drive_input(input int p);
                int gap;
                int waited;
                for (int k = 0; k < n_flits; k++) begin
                        if (f_src[k] == p) begin
                                gap = $urandom_range(2, 0);
                                repeat (gap) @(posedge clk);
                                waited = 0;
                                do begin
                                        @(posedge clk);
                                        waited++;
                                end while (send_credit[p] == 0 && waited < wait_limit);
                                if (send_credit[p] == 0) begin
                                        $display("Input %0d waited too long for credit", p);
                                        timeouts++;
                                        return;
                                end
                                drv_valid[p] <= 1'b1;
                                drv_data[p]  <= f_data[k];
                                drv_vch[p]   <= f_vch[k];
                                exp_q[p][f_dest[k]].push_back({f_vch[k], f_data[k]});
                                send_credit[p]--;
                                sent[p]++;
                                started = 1'b1;
                                @(posedge clk);
                                drv_valid[p] <= 1'b0;
                        end
                end
        endtask

        task automatic load_patterns();
                int fd;
                int code;
                int s;
                int d;
                logic [vch_w-1:0]  v;
                logic [data_w-1:0] dat;
                logic [8*16-1:0]   kind;
                logic [8*128-1:0]  line;
                fd = $fopen("router_patterns.txt", "r");
                if (fd == 0) begin
                        $display("Could not open the pattern file");
                        errors++;
                        return;
                end
                while (!$feof(fd)) begin
                        code = $fscanf(fd, "%s", kind);
                        if (code != 1) break;
                        if (kind == "F") begin
                                code = $fscanf(fd, "%d %d %h %h", s, d, v, dat);
                                if (dat[data_w-1 -: 3] != d[2:0]) begin
                                        $display("Pattern flit %h has a wrong destination field", dat);
                                        errors++;
                                end
                                f_src[n_flits]  = s;
                                f_dest[n_flits] = d;
                                f_vch[n_flits]  = v;
                                f_data[n_flits] = dat;
                                n_flits++;
                        end else if (kind == "H") begin
                                code = $fscanf(fd, "%d %d", s, d);
                                hold_left[s] = d;
                        end else begin
                                code = $fgets(line, fd);   // Comment line.
                        end
                end
                $fclose(fd);
        endtask

        // ##########################################################################
        // Output and credit monitor
        // ##########################################################################

        // Matches one flit seen on output o against the queues of all sources.
        task automatic receive_flit(input int o);
                logic [data_w-1:0] got_data;
                logic [vch_w-1:0]  got_vch;
                bit                found;
                got_data = out_data[o*data_w +: data_w];
                got_vch  = out_vch[o*vch_w +: vch_w];
                received[o]++;
                if (received[o] - returned[o] > out_credits) begin
                        $display("Output %0d sent without downstream credit", o);
                        errors++;
                end
                if (got_data[data_w-1 -: 3] != o[2:0]) begin
                        $display("ERR %0t out_data[%0d] dest expected %0d got %0d",
                                 $time, o, o, got_data[data_w-1 -: 3]);
                        errors++;
                end
                found = 1'b0;
                for (int s = 0; s < num_ports; s++) begin
                        if (!found && exp_q[s][o].size() > 0 &&
                            exp_q[s][o][0] == {got_vch, got_data}) begin
                                found = 1'b1;
                                void'(exp_q[s][o].pop_front());
                        end
                end
                if (!found) begin
                        $display("Output %0d sent unexpected or reordered flit %h vch %0d",
                                 o, got_data, got_vch);
                        errors++;
                end
                pend_credit[o]++;
        endtask

        // Counts how often a waiting input is passed over on output o.
        task automatic track_fairness(input int o);
                for (int s = 0; s < num_ports; s++) begin
                        if (dut.grant_o[o][s]) begin
                                passed[o][s] = 0;
                        end else if (dut.request[s][o]) begin
                                passed[o][s]++;
                                if (passed[o][s] > num_ports - 1) begin
                                        $display("Input %0d starved on output %0d", s, o);
                                        errors++;
                                end
                        end
                end
        endtask

        always @(posedge clk) begin
                if (reset) begin
                        out_credit <= '0;
                end else begin
                        if (!started && (out_valid != '0 || in_credit != '0)) begin
                                $display("ERR %0t out_valid/in_credit expected 0 got %b/%b",
                                         $time, out_valid, in_credit);
                                errors++;
                        end
                        for (int o = 0; o < num_ports; o++) begin
                                if (in_credit[o]) begin
                                        send_credit[o]++;
                                        credits_back[o]++;
                                end
                                if (out_valid[o]) begin
                                        receive_flit(o);
                                end
                                if (out_credit[o]) returned[o]++;
                                if (dut.grant_o[o] != '0) begin
                                        track_fairness(o);
                                end
                                if (started && hold_left[o] > 0) begin
                                        hold_left[o]--;
                                        out_credit[o] <= 1'b0;
                                end else if (pend_credit[o] > 0) begin
                                        pend_credit[o]--;
                                        out_credit[o] <= 1'b1;
                                end else begin
                                        out_credit[o] <= 1'b0;
                                end
                        end
                end
        end

        // ##########################################################################
        // Main sequence
        // ##########################################################################

        initial begin
                int  waited;
                bit  busy;
                void'($urandom(32'h6feb9fc3));
                for (int p = 0; p < num_ports; p++) begin
                        drv_valid[p]    = 1'b0;
                        drv_data[p]     = '0;
                        drv_vch[p]      = '0;
                        send_credit[p]  = buf_depth;
                        sent[p]         = 0;
                        credits_back[p] = 0;
                        received[p]     = 0;
                        returned[p]     = 0;
                        pend_credit[p]  = 0;
                        hold_left[p]    = 0;
                        for (int s = 0; s < num_ports; s++) passed[p][s] = 0;
                end
                load_patterns();
                repeat (16) @(posedge clk);
                reset <= 1'b0;
                repeat (4) @(posedge clk);
                for (int p = 0; p < num_ports; p++) begin
                        fork
                                automatic int q = p;
                                drive_input(q);
                        join_none
                end
                wait fork;
                waited = 0;
                do begin
                        @(posedge clk);
                        waited++;
                        busy = 1'b0;
                        for (int p = 0; p < num_ports; p++) begin
                                if (send_credit[p] < buf_depth) busy = 1'b1;
                                for (int d = 0; d < num_ports; d++) begin
                                        if (exp_q[p][d].size() > 0) busy = 1'b1;
                                end
                        end
                end while (busy && waited < wait_limit);
                if (busy) begin
                        $display("Router did not drain all flits and credits in time");
                        timeouts++;
                end
                for (int p = 0; p < num_ports; p++) begin
                        if (credits_back[p] != sent[p]) begin
                                $display("ERR %0t in_credit[%0d] expected %0d got %0d",
                                         $time, p, sent[p], credits_back[p]);
                                errors++;
                        end
                end
                $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
                if (errors == 0 && timeouts == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        end

endmodule

// ==== router_patterns.txt ====
# F src dest vch data : one flit, data top three bits equal dest
# H port cycles : out_credit held low on that output for cycles after traffic starts
H 3 60
F 0 0 0 01C00001
F 0 1 1 21C00101
F 0 2 2 41C00201
F 0 3 3 61C00301
F 0 4 0 81C00401
F 1 0 1 01C01001
F 1 1 2 21C01101
F 1 2 3 41C01201
F 1 3 0 61C01301
F 1 4 1 81C01401
F 2 0 2 01C02001
F 2 1 3 21C02101
F 2 2 0 41C02201
F 2 3 1 61C02301
F 2 4 2 81C02401
F 3 0 3 01C03001
F 3 1 0 21C03101
F 3 2 1 41C03201
F 3 3 2 61C03301
F 3 4 3 81C03401
F 4 0 0 01C04001
F 4 1 1 21C04101
F 4 2 2 41C04201
F 4 3 3 61C04301
F 4 4 0 81C04401
# Contention: every input loads two flits for the east output.
F 0 2 1 41C00202
F 1 2 1 41C01202
F 2 2 1 41C02202
F 3 2 1 41C03202
F 4 2 1 41C04202
F 0 2 3 41C00203
F 1 2 3 41C01203
F 2 2 3 41C02203
F 3 2 3 41C03203
F 4 2 3 41C04203
# More traffic for the south output while its credit is held.
F 0 3 2 61C00302
F 1 3 2 61C01302
F 4 3 2 61C04302
F 0 3 1 61C00303
F 1 3 1 61C01303
F 4 3 1 61C04303

// ==== build.f ====
router_pkg.sv
input_buffer.sv
switch_allocator.sv
output_port.sv
router_top.sv
router_chk.sv
router_tb.sv

// ==== Makefile ====
# Verilator build and run for the router testbench.
TOP = router_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
